// ==== src/gpu_isa_pkg.sv ====
package gpu_isa_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [31:0] pc_t;
	typedef logic [7:0]  warp_sel_t;
	typedef logic [2:0]  warp_id_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	// Four ASCII characters, first one in the top byte
	typedef logic [31:0] mnem_t;

	localparam int SCALAR_BIT = 30;

	// Opcodes written with bit 4 clear, decode treats bit 4 as don't care
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_ADDI  = 6'b001000;
	localparam opcode_t OP_ANDI  = 6'b001100;
	localparam opcode_t OP_ORI   = 6'b001101;
	localparam opcode_t OP_XORI  = 6'b001110;
	localparam opcode_t OP_LW    = 6'b100011;
	localparam opcode_t OP_LWS   = 6'b100111;
	localparam opcode_t OP_SW    = 6'b101011;
	localparam opcode_t OP_SWS   = 6'b101111;
	localparam opcode_t OP_BEQ   = 6'b000100;
	localparam opcode_t OP_BLT   = 6'b000111;
	localparam opcode_t OP_JMP   = 6'b000010;
	localparam opcode_t OP_NOOP  = 6'b000001;
	// Exact matches only
	localparam opcode_t OP_CALL  = 6'b000011;
	localparam opcode_t OP_RET   = 6'b000110;
	localparam opcode_t OP_EXIT  = 6'b100001;

	// R-type function codes
	localparam funct_t FN_ADD = 6'b100000;
	localparam funct_t FN_SUB = 6'b100010;
	localparam funct_t FN_MUL = 6'b011000;
	localparam funct_t FN_AND = 6'b100100;
	localparam funct_t FN_OR  = 6'b100101;
	localparam funct_t FN_XOR = 6'b100110;
	localparam funct_t FN_SHR = 6'b000010;
	localparam funct_t FN_SHL = 6'b000000;

	localparam mnem_t MNEM_ADD  = "ADD ";
	localparam mnem_t MNEM_SUB  = "SUB ";
	localparam mnem_t MNEM_MUL  = "MUL ";
	localparam mnem_t MNEM_AND  = "AND ";
	localparam mnem_t MNEM_OR   = "OR  ";
	localparam mnem_t MNEM_XOR  = "XOR ";
	localparam mnem_t MNEM_SHR  = "SHR ";
	localparam mnem_t MNEM_SHL  = "SHL ";
	localparam mnem_t MNEM_ADDI = "ADDI";
	localparam mnem_t MNEM_ANDI = "ANDI";
	localparam mnem_t MNEM_ORI  = "ORI ";
	localparam mnem_t MNEM_XORI = "XORI";
	localparam mnem_t MNEM_LW   = "LW  ";
	localparam mnem_t MNEM_LWS  = "LWS ";
	localparam mnem_t MNEM_SW   = "SW  ";
	localparam mnem_t MNEM_SWS  = "SWS ";
	localparam mnem_t MNEM_BEQ  = "BEQ ";
	localparam mnem_t MNEM_BLT  = "BLT ";
	localparam mnem_t MNEM_JMP  = "JMP ";
	localparam mnem_t MNEM_CALL = "CALL";
	localparam mnem_t MNEM_RET  = "RET ";
	localparam mnem_t MNEM_EXIT = "EXIT";
	localparam mnem_t MNEM_NOOP = "NOOP";
	localparam mnem_t MNEM_UNKN = "UNKN";

endpackage

// ==== src/trace_pkg.sv ====
package trace_pkg;

	import gpu_isa_pkg::*;

	localparam int TRACE_DEPTH = 16;

	typedef logic [3:0]  rec_idx_t;
	typedef logic [7:0]  cnt_t;
	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0]  axi_resp_t;

	// Source of a record
	localparam logic PORT_FETCH = 1'b0;
	localparam logic PORT_WB    = 1'b1;

	typedef struct packed {
		instr_t    instr;
		pc_t       pc;
		warp_sel_t warp_sel;
	} tap_t;

	// Port stays the lowest field, the top level stamps it
	typedef struct packed {
		mnem_t    mnem;
		pc_t      pc;
		instr_t   instr;
		warp_id_t warp;
		logic     warp_bad;
		logic     scalar;
		logic     known;
		logic     port;
	} trace_rec_t;

	// Host register map
	localparam axi_addr_t STATUS_ADDR = 32'h0000_0100;
	localparam axi_addr_t CLEAR_ADDR  = 32'h0000_0104;

	localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

// ==== src/instr_disasm.sv ====
`timescale 1ns/1ps

module instr_disasm
	import gpu_isa_pkg::*;
	import trace_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  tap_t       tap,
	input  logic       tap_valid,
	output logic       tap_ready,
	output trace_rec_t rec,
	output logic       rec_valid,
	input  logic       rec_grant
);

	trace_rec_t fmt;
	warp_id_t   warp;
	logic       warp_bad;
	logic       run;

	////////////////////////////////////////////////////////////////////////////
	// Instruction classification
	////////////////////////////////////////////////////////////////////////////

	function automatic mnem_t classify(input instr_t ins);
		opcode_t op;
		funct_t  fn;
		mnem_t   m;
		op = ins[31:26];
		fn = ins[5:0];
		m = MNEM_UNKN;
		if (op == OP_CALL) begin
			m = MNEM_CALL;
		end else if (op == OP_RET) begin
			m = MNEM_RET;
		end else if (op == OP_EXIT) begin
			m = MNEM_EXIT;
		end else begin
			// Bit 4 does not take part in the remaining opcodes
			case ({op[5], 1'b0, op[3:0]})
				OP_RTYPE: begin
					case (fn)
						FN_ADD:  m = MNEM_ADD;
						FN_SUB:  m = MNEM_SUB;
						FN_MUL:  m = MNEM_MUL;
						FN_AND:  m = MNEM_AND;
						FN_OR:   m = MNEM_OR;
						FN_XOR:  m = MNEM_XOR;
						FN_SHR:  m = MNEM_SHR;
						FN_SHL:  m = MNEM_SHL;
						default: m = MNEM_UNKN;
					endcase
				end
				OP_ADDI: m = MNEM_ADDI;
				OP_ANDI: m = MNEM_ANDI;
				OP_ORI:  m = MNEM_ORI;
				OP_XORI: m = MNEM_XORI;
				OP_LW:   m = MNEM_LW;
				OP_LWS:  m = MNEM_LWS;
				OP_SW:   m = MNEM_SW;
				OP_SWS:  m = MNEM_SWS;
				OP_BEQ:  m = MNEM_BEQ;
				OP_BLT:  m = MNEM_BLT;
				OP_JMP:  m = MNEM_JMP;
				OP_NOOP: m = MNEM_NOOP;
				default: m = MNEM_UNKN;
			endcase
		end
		return m;
	endfunction

	// One-hot warp select to warp number
	always_comb begin
		warp_bad = 1'b0;
		case (tap.warp_sel)
			8'b0000_0001: warp = 3'd0;
			8'b0000_0010: warp = 3'd1;
			8'b0000_0100: warp = 3'd2;
			8'b0000_1000: warp = 3'd3;
			8'b0001_0000: warp = 3'd4;
			8'b0010_0000: warp = 3'd5;
			8'b0100_0000: warp = 3'd6;
			8'b1000_0000: warp = 3'd7;
			default: begin
				warp = 3'd0;
				warp_bad = 1'b1;
			end
		endcase
	end

	always_comb begin
		fmt.mnem = classify(tap.instr);
		fmt.pc = tap.pc;
		fmt.instr = tap.instr;
		fmt.warp = warp;
		fmt.warp_bad = warp_bad;
		fmt.scalar = tap.instr[SCALAR_BIT];
		fmt.known = (fmt.mnem != MNEM_UNKN);
		// Replaced per instance in the top level
		fmt.port = PORT_FETCH;
	end

	////////////////////////////////////////////////////////////////////////////
	// One-entry hold toward the arbiter
	////////////////////////////////////////////////////////////////////////////

	// Ready opens once the first edge after reset has passed
	assign tap_ready = run && (!rec_valid || rec_grant);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run <= 1'b0;
			rec_valid <= 1'b0;
		end else begin
			run <= 1'b1;
			if (tap_valid && tap_ready) begin
				rec_valid <= 1'b1;
			end else if (rec_grant) begin
				rec_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tap_valid && tap_ready) begin
			rec <= fmt;
		end
	end

endmodule

// ==== src/trace_arbiter.sv ====
`timescale 1ns/1ps

module trace_arbiter
	import trace_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  trace_rec_t rec [2],
	input  logic [1:0] rec_valid,
	output logic [1:0] rec_grant,
	output trace_rec_t wr_rec,
	output logic       wr_en
);

	// Port that wins the next tie
	logic rr_ptr;
	logic sel;

	always_comb begin
		sel = rr_ptr;
		if (rec_valid[0] && !rec_valid[1]) begin
			sel = 1'b0;
		end else if (rec_valid[1] && !rec_valid[0]) begin
			sel = 1'b1;
		end
		rec_grant = 2'b00;
		if (rec_valid != 2'b00) begin
			rec_grant[sel] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr_ptr <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= (rec_grant != 2'b00);
			// Hand priority to the other port after every grant
			if (rec_grant != 2'b00) begin
				rr_ptr <= ~sel;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rec_grant != 2'b00) begin
			wr_rec <= rec[sel];
		end
	end

endmodule

// ==== src/trace_buffer.sv ====
`timescale 1ns/1ps

module trace_buffer
	import trace_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  trace_rec_t wr_rec,
	input  logic       wr_en,
	input  axi_addr_t  awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axi_data_t  wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output axi_resp_t  bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axi_addr_t  araddr,
	input  logic       arvalid,
	output logic       arready,
	output axi_data_t  rdata,
	output axi_resp_t  rresp,
	output logic       rvalid,
	input  logic       rready
);

	typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;
	typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;

	trace_rec_t mem [TRACE_DEPTH];
	rec_idx_t   wr_ptr, ptr_base;
	cnt_t       rec_cnt, cnt_base;
	cnt_t       drop_cnt, drop_base;
	rd_state_t  rd_state;
	wr_state_t  wr_state;
	trace_rec_t rd_rec;
	axi_data_t  rd_word;
	logic       aw_take, clr, full;

	////////////////////////////////////////////////////////////////////////////
	// Record store
	////////////////////////////////////////////////////////////////////////////

	// A clear in the same cycle as a write lands the write in record 0
	always_comb begin
		ptr_base = clr ? '0 : wr_ptr;
		cnt_base = clr ? '0 : rec_cnt;
		drop_base = clr ? '0 : drop_cnt;
		full = (cnt_base == cnt_t'(TRACE_DEPTH));
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rec_cnt <= '0;
			drop_cnt <= '0;
		end else begin
			wr_ptr <= ptr_base;
			rec_cnt <= cnt_base;
			drop_cnt <= drop_base;
			if (wr_en && !full) begin
				wr_ptr <= ptr_base + 1'b1;
				rec_cnt <= cnt_base + 1'b1;
			end else if (wr_en && drop_base != '1) begin
				drop_cnt <= drop_base + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && !full) begin
			mem[ptr_base] <= wr_rec;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Host read channel
	////////////////////////////////////////////////////////////////////////////

	assign arready = (rd_state == RD_IDLE);
	assign rvalid = (rd_state == RD_RESP);
	assign rresp = RESP_OKAY;

	always_comb begin
		rd_rec = mem[araddr[7:4]];
		rd_word = '0;
		if (araddr[31:8] == '0) begin
			// Four words per record
			case (araddr[3:2])
				2'd0: rd_word = rd_rec.mnem;
				2'd1: rd_word = rd_rec.pc;
				2'd2: rd_word = rd_rec.instr;
				default: rd_word = {23'b0, rd_rec.port, 2'b0, rd_rec.known,
					rd_rec.scalar, rd_rec.warp_bad, rd_rec.warp};
			endcase
		end else if ({araddr[31:2], 2'b00} == STATUS_ADDR) begin
			rd_word = {16'b0, drop_cnt, rec_cnt};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: if (arvalid) rd_state <= RD_RESP;
				default: if (rready) rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			rdata <= rd_word;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Host write channel
	////////////////////////////////////////////////////////////////////////////

	assign awready = (wr_state == WR_IDLE);
	assign wready = (wr_state == WR_IDLE);
	assign bvalid = (wr_state == WR_RESP);
	assign bresp = RESP_OKAY;

	assign aw_take = awvalid && wvalid && (wr_state == WR_IDLE);
	// The clear register has no contents, wdata and wstrb carry no meaning
	assign clr = aw_take && ({awaddr[31:2], 2'b00} == CLEAR_ADDR);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: if (aw_take) wr_state <= WR_RESP;
				default: if (bready) wr_state <= WR_IDLE;
			endcase
		end
	end

endmodule

// ==== src/trace_unit_top.sv ====
`timescale 1ns/1ps

module trace_unit_top
	import trace_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  tap_t       fetch_tap,
	input  logic       fetch_valid,
	output logic       fetch_ready,
	input  tap_t       wb_tap,
	input  logic       wb_valid,
	output logic       wb_ready,
	input  axi_addr_t  awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axi_data_t  wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output axi_resp_t  bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axi_addr_t  araddr,
	input  logic       arvalid,
	output logic       arready,
	output axi_data_t  rdata,
	output axi_resp_t  rresp,
	output logic       rvalid,
	input  logic       rready
);

	trace_rec_t fmt_rec [2];
	trace_rec_t arb_rec [2];
	logic [1:0] rec_valid;
	logic [1:0] rec_grant;
	logic [1:0] tap_ready;
	trace_rec_t wr_rec;
	logic       wr_en;

	assign fetch_ready = tap_ready[0];
	assign wb_ready = tap_ready[1];

	// Formatter 0 watches fetch, formatter 1 watches writeback
	for (genvar g = 0; g < 2; g++) begin : g_fmt
		instr_disasm i_instr_disasm (
			.clk       (clk),
			.rst_n     (rst_n),
			.tap       ((g == 0) ? fetch_tap : wb_tap),
			.tap_valid ((g == 0) ? fetch_valid : wb_valid),
			.tap_ready (tap_ready[g]),
			.rec       (fmt_rec[g]),
			.rec_valid (rec_valid[g]),
			.rec_grant (rec_grant[g])
		);

		// Port number comes from the generate index
		assign arb_rec[g] = {fmt_rec[g][$bits(trace_rec_t)-1:1],
			(g == 0) ? PORT_FETCH : PORT_WB};
	end

	trace_arbiter i_trace_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.rec       (arb_rec),
		.rec_valid (rec_valid),
		.rec_grant (rec_grant),
		.wr_rec    (wr_rec),
		.wr_en     (wr_en)
	);

	trace_buffer i_trace_buffer (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_rec  (wr_rec),
		.wr_en   (wr_en),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

endmodule

// ==== tests/tb_trace_unit_top.sv ====
`timescale 1ns/1ps

module tb_trace_unit_top
	import gpu_isa_pkg::*;
	import trace_pkg::*;
();

	localparam int SEED = 32'h3616f850;
	// About 40 tap transfers and 150 host accesses of a few cycles each
	localparam int MAX_CYCLES = 4000;

	localparam opcode_t OP_LIST [16] = '{OP_RTYPE, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
		OP_LW, OP_LWS, OP_SW, OP_SWS, OP_BEQ, OP_BLT, OP_JMP, OP_NOOP, OP_CALL, OP_RET,
		OP_EXIT};
	localparam funct_t FN_LIST [8] = '{FN_ADD, FN_SUB, FN_MUL, FN_AND, FN_OR, FN_XOR,
		FN_SHR, FN_SHL};

	logic       clk;
	logic       rst_n;
	tap_t       tap_in [2];
	logic       tap_vld [2];
	logic       tap_rdy [2];
	axi_addr_t  awaddr;
	logic       awvalid;
	logic       awready;
	axi_data_t  wdata;
	logic [3:0] wstrb;
	logic       wvalid;
	logic       wready;
	axi_resp_t  bresp;
	logic       bvalid;
	logic       bready;
	axi_addr_t  araddr;
	logic       arvalid;
	logic       arready;
	axi_data_t  rdata;
	axi_resp_t  rresp;
	logic       rvalid;
	logic       rready;

	// Expected records per port in acceptance order
	trace_rec_t hist [2][$];
	// First entry of each queue after the last clear
	int         base [2];
	int         cycle;
	int         errors;

	trace_unit_top i_trace_unit_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_tap   (tap_in[0]),
		.fetch_valid (tap_vld[0]),
		.fetch_ready (tap_rdy[0]),
		.wb_tap      (tap_in[1]),
		.wb_valid    (tap_vld[1]),
		.wb_ready    (tap_rdy[1]),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycle = 0;
		while (cycle < MAX_CYCLES) begin
			@(posedge clk);
			cycle++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s got %h expected %h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic mnem_t model_mnem(input instr_t w);
		logic [5:0] op;
		logic [5:0] key;
		mnem_t      m;
		op = w[31:26];
		key = {op[5], 1'b0, op[3:0]};
		m = "UNKN";
		if (op == 6'b000011) m = "CALL";
		else if (op == 6'b000110) m = "RET ";
		else if (op == 6'b100001) m = "EXIT";
		else if (key == 6'b000000) begin
			case (w[5:0])
				6'b100000: m = "ADD ";
				6'b100010: m = "SUB ";
				6'b011000: m = "MUL ";
				6'b100100: m = "AND ";
				6'b100101: m = "OR  ";
				6'b100110: m = "XOR ";
				6'b000010: m = "SHR ";
				6'b000000: m = "SHL ";
				default:   m = "UNKN";
			endcase
		end else begin
			case (key)
				6'b001000: m = "ADDI";
				6'b001100: m = "ANDI";
				6'b001101: m = "ORI ";
				6'b001110: m = "XORI";
				6'b100011: m = "LW  ";
				6'b100111: m = "LWS ";
				6'b101011: m = "SW  ";
				6'b101111: m = "SWS ";
				6'b000100: m = "BEQ ";
				6'b000111: m = "BLT ";
				6'b000010: m = "JMP ";
				6'b000001: m = "NOOP";
				default:   m = "UNKN";
			endcase
		end
		return m;
	endfunction

	function automatic trace_rec_t model_rec(input tap_t t, input int p);
		trace_rec_t e;
		e.mnem = model_mnem(t.instr);
		e.pc = t.pc;
		e.instr = t.instr;
		e.warp_bad = ($countones(t.warp_sel) != 1);
		e.warp = 3'd0;
		for (int i = 0; i < 8; i++) begin
			if (!e.warp_bad && t.warp_sel[i]) e.warp = 3'(i);
		end
		e.scalar = t.instr[30];
		e.known = (e.mnem != "UNKN");
		e.port = p[0];
		return e;
	endfunction

	// Word 3 of a record
	function automatic axi_data_t flags_word(input trace_rec_t e);
		axi_data_t w;
		w = '0;
		w[8] = e.port;
		w[5] = e.known;
		w[4] = e.scalar;
		w[3] = e.warp_bad;
		w[2:0] = e.warp;
		return w;
	endfunction

	// Mostly listed opcodes and functs with random bit 4 and sometimes raw words
	function automatic tap_t random_tap();
		tap_t    t;
		opcode_t op;
		t.instr = $urandom();
		if ($urandom_range(0, 4) != 0) begin
			op = OP_LIST[$urandom_range(0, 15)];
			if ($urandom_range(0, 3) == 0) op[4] = 1'b1;
			t.instr[31:26] = op;
			if ($urandom_range(0, 3) != 0) t.instr[5:0] = FN_LIST[$urandom_range(0, 7)];
		end
		t.pc = $urandom() & 32'hffff_fffc;
		if ($urandom_range(0, 3) != 0) begin
			t.warp_sel = 8'd1 << $urandom_range(0, 7);
		end else begin
			t.warp_sel = 8'($urandom());
		end
		return t;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Tap and host drivers
	////////////////////////////////////////////////////////////////////////////

	// busy keeps valid high, so the port must accept at least every other cycle
	task automatic drive_port(input int p, input int n, input bit busy);
		int done;
		int last;
		bit hold;
		done = 0;
		last = -1;
		hold = 1'b0;
		while (done < n) begin
			@(posedge clk);
			#1;
			if (!hold) begin
				tap_vld[p] = busy || ($urandom_range(0, 9) < 6);
				if (tap_vld[p]) tap_in[p] = random_tap();
			end
			@(negedge clk);
			hold = 1'b0;
			if (tap_vld[p] && tap_rdy[p]) begin
				hist[p].push_back(model_rec(tap_in[p], p));
				if (busy && last >= 0) begin
					check(32'(cycle - last <= 2), 1, "tap starved while both taps valid");
				end
				last = cycle;
				done++;
			end else if (tap_vld[p]) begin
				hold = 1'b1;
			end
		end
		@(posedge clk);
		#1;
		tap_vld[p] = 1'b0;
	endtask

	task automatic read_word(input axi_addr_t addr, output axi_data_t data);
		@(posedge clk);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid) @(negedge clk);
		data = rdata;
		check(32'(rresp), 32'(RESP_OKAY), "read response");
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic write_word(input axi_addr_t addr, input axi_data_t data);
		@(posedge clk);
		#1;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		@(negedge clk);
		while (!(awready && wready)) @(negedge clk);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		while (!bvalid) @(negedge clk);
		check(32'(bresp), 32'(RESP_OKAY), "write response");
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic check_status(input int cnt, input int drops);
		axi_data_t d;
		read_word(STATUS_ADDR, d);
		check(d, {16'b0, 8'(drops), 8'(cnt)}, "status word");
	endtask

	// Port bit of each record picks the queue it must match next
	task automatic check_records(input int n);
		int         pos [2];
		int         p;
		axi_data_t  d;
		trace_rec_t e;
		pos[0] = base[0];
		pos[1] = base[1];
		for (int i = 0; i < n; i++) begin
			read_word(axi_addr_t'(i * 16 + 12), d);
			p = int'(d[8]);
			check(32'(pos[p] < hist[p].size()), 1, "record without a matching transfer");
			e = hist[p][pos[p]];
			pos[p]++;
			check(d, flags_word(e), "flags word");
			read_word(axi_addr_t'(i * 16), d);
			check(d, e.mnem, "mnemonic");
			read_word(axi_addr_t'(i * 16 + 4), d);
			check(d, e.pc, "pc");
			read_word(axi_addr_t'(i * 16 + 8), d);
			check(d, e.instr, "instruction");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		axi_data_t d;
		int        total;
		errors = 0;
		rst_n = 1'b0;
		tap_in[0] = '0;
		tap_in[1] = '0;
		tap_vld[0] = 1'b0;
		tap_vld[1] = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		base[0] = 0;
		base[1] = 0;
		void'($urandom(SEED));
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Sparse traffic, then both taps streaming
		fork
			drive_port(0, 4, 1'b0);
			drive_port(1, 5, 1'b0);
		join
		fork
			drive_port(0, 3, 1'b1);
			drive_port(1, 3, 1'b1);
		join
		repeat (4) @(posedge clk);
		check_status(15, 0);
		check_records(15);

		// Overflow keeps the oldest 16
		fork
			drive_port(0, 10, 1'b0);
			drive_port(1, 10, 1'b0);
		join
		repeat (4) @(posedge clk);
		total = hist[0].size() + hist[1].size();
		check_status(16, total - 16);
		check_records(16);

		write_word(CLEAR_ADDR, $urandom());
		check_status(0, 0);
		base[0] = hist[0].size();
		base[1] = hist[1].size();
		fork
			drive_port(0, 3, 1'b0);
			drive_port(1, 2, 1'b0);
		join
		repeat (4) @(posedge clk);
		check_status(5, 0);
		check_records(5);
		read_word(32'h0000_0200, d);
		check(d, 32'h0, "unused address");
		read_word(32'h0000_0108, d);
		check(d, 32'h0, "unused address");

		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== trace_unit_top.f ====
src/gpu_isa_pkg.sv
src/trace_pkg.sv
src/instr_disasm.sv
src/trace_arbiter.sv
src/trace_buffer.sv
src/trace_unit_top.sv
tests/tb_trace_unit_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_trace_unit_top
RTL_TOP    := trace_unit_top
FILELIST   := trace_unit_top.f
VFLAGS     := --binary --timing -j 0 -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		src/gpu_isa_pkg.sv src/trace_pkg.sv src/instr_disasm.sv \
		src/trace_arbiter.sv src/trace_buffer.sv src/trace_unit_top.sv

clean:
	rm -rf obj_dir
